//--- design/sdram_pkg.sv
// Shared types and download layout; assumes sound ROMs sit below BA2_START and tiles start there
package sdram_pkg;

    // One SDRAM data word
    typedef logic [15:0] sdram_word_t;

    // Sound CPU and ADPCM payload
    typedef logic [7:0] byte_t;

    // Tile payload, two SDRAM words with the first word in the upper half
    typedef logic [31:0] quad_t;

    // Word address inside one bank
    typedef logic [21:0] sdram_addr_t;

    // Download byte address where tile data begins
    localparam logic [24:0] BA2_START = 25'h04_0000;

    // Words of the first tile set, the one stored with planes interleaved
    localparam sdram_addr_t GFX1_LEN = 22'h01_0000;

    // Checksums of bytes 0 to 7 that identify the alternate game
    localparam byte_t ALT_SUM_A = 8'h0c;
    localparam byte_t ALT_SUM_B = 8'hf4;

    // Game id codes
    localparam logic [1:0] GAME_STD = 2'd0;
    localparam logic [1:0] GAME_ALT = 2'd1;

endpackage

//--- design/rom_slot.sv
// Payload must be 8 or 32 bits; client holds cs and addr steady until ok, and clr drops a pending req
module rom_slot import sdram_pkg::*; #(
    parameter type payload_t = byte_t,
    parameter int  AW        = 16
) (
    input  logic          clk,
    input  logic          arst_n,
    // Client side
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output payload_t      dout,
    output logic          ok,
    input  logic          clr,
    // Arbiter side
    output logic          req,
    output sdram_addr_t   req_addr,
    input  logic          fill,
    input  quad_t         fill_data
);
    localparam bit IS_BYTE = ($bits(payload_t) == 8);
    localparam int DW      = IS_BYTE ? 16 : 32;

    logic          valid;
    logic          hit;
    sdram_addr_t   cached_addr;
    logic [DW-1:0] data;

    generate
        if (IS_BYTE) begin : g_byte
            // Two bytes share one SDRAM word, low byte at the even address
            assign req_addr = sdram_addr_t'(addr[AW-1:1]);
            assign dout     = payload_t'(addr[0] ? data[15:8] : data[7:0]);
        end else begin : g_quad
            assign req_addr = sdram_addr_t'(addr);
            assign dout     = payload_t'(data);
        end
    endgenerate

    assign hit = valid && (cached_addr == req_addr);

    // Hits answer in the same cycle as cs
    assign ok = cs && hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else begin
            if (clr) begin
                valid <= 1'b0;
                req   <= 1'b0;
            end else if (fill && req) begin
                valid <= 1'b1;
                req   <= 1'b0;
            end else if (cs && !hit) begin
                // Miss, stays requested until filled even if cs drops
                req <= 1'b1;
            end
        end
    end

    // Late fills after a clear are ignored since req is already low
    always_ff @(posedge clk) begin
        if (fill && req && !clr) begin
            cached_addr <= req_addr;
            data        <= fill_data[DW-1:0];
        end
    end

endmodule

//--- design/bank_arbiter.sv
// One read in flight per bank; the controller marks a two-word read with dst then rdy, one-word reads with both
module bank_arbiter import sdram_pkg::*; #(
    parameter int          SLOT0_WORDS  = 1,
    parameter int          SLOT1_WORDS  = 1,
    parameter sdram_addr_t SLOT1_OFFSET = '0
) (
    input  logic        clk,
    input  logic        arst_n,
    // Slot side
    input  logic        req0,
    input  logic        req1,
    input  sdram_addr_t addr0,
    input  sdram_addr_t addr1,
    output logic        fill0,
    output logic        fill1,
    output quad_t       fill_data,
    // SDRAM controller side
    output logic        sdram_rd,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_dst,
    input  logic        data_rdy,
    input  sdram_word_t data_read
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_t;

    state_t state;
    logic   grant;
    logic   take0;
    logic   take1;
    logic   word_in;
    logic   two_words;

    // The slot being filled still shows req for this one cycle
    assign take0 = req0 && !fill0;
    assign take1 = req1 && !fill1;

    assign word_in   = (state == ST_WAIT) && (data_dst || data_rdy);
    assign two_words = grant ? (SLOT1_WORDS == 2) : (SLOT0_WORDS == 2);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= ST_IDLE;
            grant    <= 1'b0;
            sdram_rd <= 1'b0;
            fill0    <= 1'b0;
            fill1    <= 1'b0;
        end else begin
            fill0 <= 1'b0;
            fill1 <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // Slot 0 wins ties
                    if (take0) begin
                        grant    <= 1'b0;
                        sdram_rd <= 1'b1;
                        state    <= ST_REQ;
                    end else if (take1) begin
                        grant    <= 1'b1;
                        sdram_rd <= 1'b1;
                        state    <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        sdram_rd <= 1'b0;
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) begin
                        fill0 <= !grant;
                        fill1 <= grant;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // Address latched at grant and held through the ack
        if (state == ST_IDLE) begin
            if (take0) begin
                sdram_addr <= addr0;
            end else if (take1) begin
                sdram_addr <= addr1 + SLOT1_OFFSET;
            end
        end
        // First word shifts up into bits 31:16
        if (word_in) begin
            if (two_words) begin
                fill_data <= {fill_data[15:0], data_read};
            end else begin
                fill_data <= {16'h0000, data_read};
            end
        end
    end

endmodule

//--- design/prog_remap.sv
// Loader bytes at least 8 cycles apart and even byte first; bytes seen while downloading is low are dropped
module prog_remap import sdram_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    // ROM loader
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    // SDRAM write port
    output sdram_addr_t prog_addr,
    output sdram_word_t prog_data,
    output logic [1:0]  prog_mask,
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    input  logic        prog_ack,
    output logic [1:0]  game_id
);
    logic        is_ba2;
    logic [22:0] ba2_offset;
    sdram_addr_t ba2_word;
    sdram_addr_t word_addr;
    logic        byte_swap;
    logic        byte_wr;
    logic        word_wr;
    byte_t       even_byte;
    byte_t       rom_sum;

    assign is_ba2     = (ioctl_addr >= BA2_START);
    assign ba2_offset = ioctl_addr[22:0] - BA2_START[22:0];
    assign ba2_word   = ba2_offset[22:1];

    // Bit 15 moves to bit 0 inverted so both plane halves share a 32-bit read
    always_comb begin
        if (!is_ba2) begin
            word_addr = ioctl_addr[22:1];
        end else if (ba2_word < GFX1_LEN) begin
            word_addr = {ba2_word[21:16], ba2_word[14:0], ~ba2_word[15]};
        end else begin
            word_addr = ba2_word;
        end
    end

    // Alternate game keeps tile bytes in the other order
    assign byte_swap = is_ba2 && (game_id == GAME_ALT);

    assign byte_wr   = downloading && ioctl_wr;
    assign word_wr   = byte_wr && ioctl_addr[0];
    assign prog_mask = 2'b00;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            game_id <= GAME_STD;
            rom_sum <= '0;
        end else begin
            if (word_wr) begin
                prog_we <= 1'b1;
            end else if (prog_ack) begin
                prog_we <= 1'b0;
            end
            if (!downloading) begin
                rom_sum <= '0;
            end else if (ioctl_wr && (ioctl_addr < 25'd8)) begin
                rom_sum <= rom_sum + ioctl_dout;
            end
            // Checksum of the header decides the game
            if (byte_wr && (ioctl_addr == 25'd8)) begin
                if ((rom_sum == ALT_SUM_A) || (rom_sum == ALT_SUM_B)) begin
                    game_id <= GAME_ALT;
                end else begin
                    game_id <= GAME_STD;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_wr && !ioctl_addr[0]) begin
            even_byte <= ioctl_dout;
        end
        if (word_wr) begin
            prog_addr <= word_addr;
            prog_ba   <= is_ba2 ? 2'd2 : 2'd1;
            prog_data <= byte_swap ? {even_byte, ioctl_dout} : {ioctl_dout, even_byte};
        end
    end

endmodule

//--- design/sdram_mux_top.sv
// Read-only sound and tile banks only; offsets are word addresses inside each bank
module sdram_mux_top import sdram_pkg::*; #(
    parameter sdram_addr_t PCM_OFFSET  = 22'h01_0000,
    parameter sdram_addr_t GFX2_OFFSET = 22'h10_0000,
    parameter int          SND_AW      = 16,
    parameter int          PCM_AW      = 17,
    parameter int          GFX_AW      = 18
) (
    input  logic              clk,
    input  logic              arst_n,
    // Sound CPU ROM
    input  logic              snd_cs,
    input  logic [SND_AW-1:0] snd_addr,
    output byte_t             snd_dout,
    output logic              snd_ok,
    // ADPCM sample ROM
    input  logic              pcm_cs,
    input  logic [PCM_AW-1:0] pcm_addr,
    output byte_t             pcm_dout,
    output logic              pcm_ok,
    // Tile ROMs
    input  logic              gfx0_cs,
    input  logic [GFX_AW-1:0] gfx0_addr,
    output quad_t             gfx0_dout,
    output logic              gfx0_ok,
    input  logic              gfx1_cs,
    input  logic [GFX_AW-1:0] gfx1_addr,
    output quad_t             gfx1_dout,
    output logic              gfx1_ok,
    // Bank 1, sound
    output logic              ba1_rd,
    output sdram_addr_t       ba1_addr,
    input  logic              ba1_ack,
    input  logic              ba1_dst,
    input  logic              ba1_rdy,
    // Bank 2, tiles
    output logic              ba2_rd,
    output sdram_addr_t       ba2_addr,
    input  logic              ba2_ack,
    input  logic              ba2_dst,
    input  logic              ba2_rdy,
    input  sdram_word_t       data_read,
    // ROM download
    input  logic              downloading,
    input  logic [24:0]       ioctl_addr,
    input  byte_t             ioctl_dout,
    input  logic              ioctl_wr,
    output sdram_addr_t       prog_addr,
    output sdram_word_t       prog_data,
    output logic [1:0]        prog_mask,
    output logic [1:0]        prog_ba,
    output logic              prog_we,
    input  logic              prog_ack,
    output logic [1:0]        game_id
);
    logic        snd_req, pcm_req, gfx0_req, gfx1_req;
    logic        snd_fill, pcm_fill, gfx0_fill, gfx1_fill;
    sdram_addr_t snd_word, pcm_word, gfx0_word, gfx1_word;
    quad_t       ba1_data, ba2_data;

    prog_remap u_remap (
        .clk(clk), .arst_n(arst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_ba(prog_ba), .prog_we(prog_we), .prog_ack(prog_ack), .game_id(game_id)
    );

    // Bank 1, sound CPU then ADPCM
    rom_slot #(.payload_t(byte_t), .AW(SND_AW)) u_snd (
        .clk(clk), .arst_n(arst_n), .cs(snd_cs), .addr(snd_addr), .dout(snd_dout),
        .ok(snd_ok), .clr(downloading), .req(snd_req), .req_addr(snd_word),
        .fill(snd_fill), .fill_data(ba1_data)
    );

    rom_slot #(.payload_t(byte_t), .AW(PCM_AW)) u_pcm (
        .clk(clk), .arst_n(arst_n), .cs(pcm_cs), .addr(pcm_addr), .dout(pcm_dout),
        .ok(pcm_ok), .clr(downloading), .req(pcm_req), .req_addr(pcm_word),
        .fill(pcm_fill), .fill_data(ba1_data)
    );

    bank_arbiter #(.SLOT0_WORDS(1), .SLOT1_WORDS(1), .SLOT1_OFFSET(PCM_OFFSET)) u_bank1 (
        .clk(clk), .arst_n(arst_n), .req0(snd_req), .req1(pcm_req),
        .addr0(snd_word), .addr1(pcm_word), .fill0(snd_fill), .fill1(pcm_fill),
        .fill_data(ba1_data), .sdram_rd(ba1_rd), .sdram_addr(ba1_addr),
        .sdram_ack(ba1_ack), .data_dst(ba1_dst), .data_rdy(ba1_rdy), .data_read(data_read)
    );

    // Bank 2, two tile clients with 32-bit reads
    rom_slot #(.payload_t(quad_t), .AW(GFX_AW)) u_gfx0 (
        .clk(clk), .arst_n(arst_n), .cs(gfx0_cs), .addr(gfx0_addr), .dout(gfx0_dout),
        .ok(gfx0_ok), .clr(downloading), .req(gfx0_req), .req_addr(gfx0_word),
        .fill(gfx0_fill), .fill_data(ba2_data)
    );

    rom_slot #(.payload_t(quad_t), .AW(GFX_AW)) u_gfx1 (
        .clk(clk), .arst_n(arst_n), .cs(gfx1_cs), .addr(gfx1_addr), .dout(gfx1_dout),
        .ok(gfx1_ok), .clr(downloading), .req(gfx1_req), .req_addr(gfx1_word),
        .fill(gfx1_fill), .fill_data(ba2_data)
    );

    bank_arbiter #(.SLOT0_WORDS(2), .SLOT1_WORDS(2), .SLOT1_OFFSET(GFX2_OFFSET)) u_bank2 (
        .clk(clk), .arst_n(arst_n), .req0(gfx0_req), .req1(gfx1_req),
        .addr0(gfx0_word), .addr1(gfx1_word), .fill0(gfx0_fill), .fill1(gfx1_fill),
        .fill_data(ba2_data), .sdram_rd(ba2_rd), .sdram_addr(ba2_addr),
        .sdram_ack(ba2_ack), .data_dst(ba2_dst), .data_rdy(ba2_rdy), .data_read(data_read)
    );

endmodule

//--- sim/sdram_mux_properties.sv
// Bound into the mux top; assumes the controller only acks a raised rd
module sdram_mux_properties (
    input logic clk,
    input logic arst_n,
    input logic ba1_rd,
    input logic ba1_ack,
    input logic ba1_dst,
    input logic ba1_rdy,
    input logic ba2_rd,
    input logic ba2_ack,
    input logic ba2_dst,
    input logic ba2_rdy,
    input logic prog_we,
    input logic prog_ack
);
    // Acked read waiting for its data, per bank
    logic ba1_pend;
    logic ba2_pend;

    // Raised by any assertion failure
    logic prop_fail = 1'b0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ba1_pend <= 1'b0;
            ba2_pend <= 1'b0;
        end else begin
            if (ba1_rd && ba1_ack) ba1_pend <= 1'b1;
            else if (ba1_rdy) ba1_pend <= 1'b0;
            if (ba2_rd && ba2_ack) ba2_pend <= 1'b1;
            else if (ba2_rdy) ba2_pend <= 1'b0;
        end
    end

    a_ba1_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ba1_rd && !ba1_ack |=> ba1_rd)
    else begin
        prop_fail = 1'b1;
        $error("bank 1 rd dropped before ack");
    end
    a_ba2_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ba2_rd && !ba2_ack |=> ba2_rd)
    else begin
        prop_fail = 1'b1;
        $error("bank 2 rd dropped before ack");
    end
    a_ba1_data: assert property (@(posedge clk) disable iff (!arst_n)
        ba1_dst || ba1_rdy |-> ba1_pend)
    else begin
        prop_fail = 1'b1;
        $error("bank 1 data without acked read");
    end
    a_ba2_data: assert property (@(posedge clk) disable iff (!arst_n)
        ba2_dst || ba2_rdy |-> ba2_pend)
    else begin
        prop_fail = 1'b1;
        $error("bank 2 data without acked read");
    end
    a_prog_hold: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we && !prog_ack |=> prog_we)
    else begin
        prop_fail = 1'b1;
        $error("prog_we dropped before ack");
    end

endmodule

bind sdram_mux_top sdram_mux_properties props_i (.*);

//--- sim/tb_top.sv
// Runs the whole mux against a behavioural SDRAM model that serves one bank read at a time
module tb_top import sdram_pkg::*;;
    localparam sdram_addr_t PCM_OFFSET  = 22'h01_0000;
    localparam sdram_addr_t GFX2_OFFSET = 22'h10_0000;
    localparam int          TIMEOUT     = 400;

    logic clk = 1'b0;
    logic arst_n;
    logic snd_cs, pcm_cs, gfx0_cs, gfx1_cs;
    logic [15:0] snd_addr;
    logic [16:0] pcm_addr;
    logic [17:0] gfx0_addr, gfx1_addr;
    byte_t snd_dout, pcm_dout;
    quad_t gfx0_dout, gfx1_dout;
    logic snd_ok, pcm_ok, gfx0_ok, gfx1_ok;
    logic ba1_rd, ba1_ack, ba1_dst, ba1_rdy, ba2_rd, ba2_ack, ba2_dst, ba2_rdy;
    sdram_addr_t ba1_addr, ba2_addr, prog_addr;
    sdram_word_t data_read, prog_data;
    logic downloading, ioctl_wr, prog_we, prog_ack;
    logic [24:0] ioctl_addr;
    byte_t ioctl_dout;
    logic [1:0] prog_mask, prog_ba, game_id;

    // Written SDRAM words per bank, keyed by word address
    logic [15:0] mem1 [int];
    logic [15:0] mem2 [int];
    integer seed = 32'h25b2;
    integer model_seed = 32'h25b2;
    int ba1_reads = 0;
    int ba2_reads = 0;
    byte_t hdr_sum;
    byte_t last_even;
    logic [1:0] exp_game;

    sdram_mux_top #(.PCM_OFFSET(PCM_OFFSET), .GFX2_OFFSET(GFX2_OFFSET)) dut_i (.*);

    always #50 clk = ~clk;

    // Unwritten words read back a pattern built from bank and full address
    function automatic logic [15:0] mem_word(input int bank, input sdram_addr_t a);
        if (bank == 1 && mem1.exists(int'(a))) return mem1[int'(a)];
        if (bank == 2 && mem2.exists(int'(a))) return mem2[int'(a)];
        return a[15:0] ^ {a[21:16], 10'h155} ^ (bank == 1 ? 16'h3c00 : 16'hc35a);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Verification failed");
        $fatal(1, "Timeout");
    endtask

    // Stop at the first failure of a bound assertion
    always @(posedge clk) begin
        if (dut_i.props_i.prop_fail) begin
            $display("A bound SDRAM assertion failed");
            $display("Verification failed");
            $fatal(1, "Assertion failure");
        end
    end

    // SDRAM controller model, ack after 1 to 4 cycles and data 2 to 5 cycles later
    task automatic serve_read(input int bank);
        sdram_addr_t a;
        int n;
        a = (bank == 1) ? ba1_addr : ba2_addr;
        if (bank == 1) ba1_reads++;
        else ba2_reads++;
        n = $random(model_seed) & 3;
        repeat (n) @(posedge clk);
        #1;
        if (bank == 1) ba1_ack = 1'b1;
        else ba2_ack = 1'b1;
        @(posedge clk);
        #1;
        ba1_ack = 1'b0;
        ba2_ack = 1'b0;
        n = 1 + ($random(model_seed) & 3);
        repeat (n) @(posedge clk);
        #1;
        data_read = mem_word(bank, a);
        if (bank == 1) begin
            ba1_dst = 1'b1;
            ba1_rdy = 1'b1;
        end else begin
            ba2_dst = 1'b1;
            @(posedge clk);
            #1;
            ba2_dst   = 1'b0;
            ba2_rdy   = 1'b1;
            data_read = mem_word(bank, a + 22'd1);
        end
        @(posedge clk);
        #1;
        {ba1_dst, ba1_rdy, ba2_dst, ba2_rdy} = 4'b0000;
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (ba1_rd) serve_read(1);
            else if (ba2_rd) serve_read(2);
        end
    end

    task automatic send_byte(input logic [24:0] a, input byte_t d);
        logic [21:0] w;
        logic [21:0] exp_addr;
        logic [15:0] exp_data;
        int n;
        @(posedge clk);
        #1;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        if (a < 25'd8) hdr_sum += d;
        if (a == 25'd8) begin
            exp_game = (hdr_sum == ALT_SUM_A || hdr_sum == ALT_SUM_B) ? GAME_ALT : GAME_STD;
            check("game_id", exp_game, game_id);
        end
        if (!a[0]) begin
            last_even = d;
        end else begin
            if (a < BA2_START) begin
                exp_addr = a[22:1];
                exp_data = {d, last_even};
            end else begin
                w = (a - BA2_START) >> 1;
                // Plane interleave inside the first tile set
                if (w < GFX1_LEN) exp_addr = ((w >> 16) << 16) | ((w & 22'h7fff) << 1) | !w[15];
                else exp_addr = w;
                exp_data = (exp_game == GAME_ALT) ? {last_even, d} : {d, last_even};
            end
            n = 0;
            while (!prog_we) begin
                @(posedge clk);
                n++;
                if (n > TIMEOUT) timeout_fail("prog_we");
            end
            check("prog_ba", (a < BA2_START) ? 2'd1 : 2'd2, prog_ba);
            check("prog_addr", exp_addr, prog_addr);
            check("prog_data", exp_data, prog_data);
            check("prog_mask", 2'b00, prog_mask);
            if (a < BA2_START) mem1[int'(exp_addr)] = exp_data;
            else mem2[int'(exp_addr)] = exp_data;
            prog_ack = 1'b1;
            @(posedge clk);
            #1;
            prog_ack = 1'b0;
            check("prog_we drop", 1'b0, prog_we);
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic download(input bit alt);
        byte_t d;
        hdr_sum = 8'h00;
        @(posedge clk);
        #1;
        downloading = 1'b1;
        for (int i = 0; i < 32; i++) begin
            d = $random(seed);
            // Last header byte forces the alternate checksum
            if (alt && i == 7) d = ALT_SUM_A - hdr_sum;
            send_byte(25'(i), d);
        end
        for (int i = 0; i < 96; i++) begin
            d = $random(seed);
            send_byte(BA2_START + 25'h1_0000 * (i / 32) + 25'(i % 32), d);
        end
        @(posedge clk);
        #1;
        downloading = 1'b0;
    endtask

    task automatic read_byte(input bit use_pcm, input logic [16:0] a, input string name);
        sdram_word_t word;
        byte_t got;
        logic seen;
        int n;
        @(posedge clk);
        #1;
        if (use_pcm) begin
            pcm_cs   = 1'b1;
            pcm_addr = a;
            word     = mem_word(1, sdram_addr_t'(a >> 1) + PCM_OFFSET);
        end else begin
            snd_cs   = 1'b1;
            snd_addr = a[15:0];
            word     = mem_word(1, sdram_addr_t'(a[15:1]));
        end
        seen = 1'b0;
        n = 0;
        while (!seen) begin
            @(posedge clk);
            seen = use_pcm ? pcm_ok : snd_ok;
            got  = use_pcm ? pcm_dout : snd_dout;
            n++;
            if (n > TIMEOUT) timeout_fail(name);
        end
        check(name, a[0] ? word[15:8] : word[7:0], got);
        #1;
        snd_cs = 1'b0;
        pcm_cs = 1'b0;
    endtask

    task automatic read_gfx(input logic [17:0] a0, input logic [17:0] a1);
        bit done0, done1;
        int n;
        @(posedge clk);
        #1;
        {gfx0_cs, gfx1_cs} = 2'b11;
        gfx0_addr = a0;
        gfx1_addr = a1;
        done0 = 0;
        done1 = 0;
        n = 0;
        while (!(done0 && done1)) begin
            @(posedge clk);
            if (gfx0_ok && !done0) begin
                check("gfx0", {mem_word(2, a0), mem_word(2, a0 + 22'd1)}, gfx0_dout);
                done0 = 1;
            end
            if (gfx1_ok && !done1) begin
                check("gfx1", {mem_word(2, a1 + GFX2_OFFSET),
                               mem_word(2, a1 + GFX2_OFFSET + 22'd1)}, gfx1_dout);
                done1 = 1;
            end
            n++;
            if (n > TIMEOUT) timeout_fail("graphics reads");
        end
        #1;
        {gfx0_cs, gfx1_cs} = 2'b00;
    endtask

    // Cached address answers in the cycle of cs
    task automatic hit_byte(input logic [15:0] a);
        sdram_word_t word;
        @(posedge clk);
        #1;
        snd_cs   = 1'b1;
        snd_addr = a;
        #1;
        word = mem_word(1, sdram_addr_t'(a[15:1]));
        check("hit ok", 1'b1, snd_ok);
        check("hit data", a[0] ? word[15:8] : word[7:0], snd_dout);
        @(posedge clk);
        #1;
        snd_cs = 1'b0;
    endtask

    initial begin
        int rd_before;
        arst_n = 1'b0;
        {snd_cs, pcm_cs, gfx0_cs, gfx1_cs} = 4'b0000;
        snd_addr = '0;
        pcm_addr = '0;
        gfx0_addr = '0;
        gfx1_addr = '0;
        {ba1_ack, ba1_dst, ba1_rdy, ba2_ack, ba2_dst, ba2_rdy} = 6'b0;
        data_read = '0;
        {downloading, ioctl_wr, prog_ack} = 3'b000;
        ioctl_addr = '0;
        ioctl_dout = '0;
        exp_game = GAME_STD;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check("reset rd", 2'b00, {ba1_rd, ba2_rd});
        check("reset prog_we", 1'b0, prog_we);
        check("reset ok", 4'b0000, {snd_ok, pcm_ok, gfx0_ok, gfx1_ok});
        check("reset game_id", GAME_STD, game_id);

        download(1'b0);
        download(1'b1);
        check("alt game_id", GAME_ALT, game_id);

        for (int i = 0; i < 16; i++) begin
            read_byte(1'b0, 17'($random(seed)) & 17'h3f, "snd read");
            read_byte(1'b1, 17'($random(seed)), "pcm read");
        end
        for (int i = 0; i < 12; i++) begin
            read_gfx(18'($random(seed)) & 18'h3f, 18'($random(seed)));
        end

        read_byte(1'b0, 17'h0006, "snd fill");
        rd_before = ba1_reads;
        hit_byte(16'h0007);
        // Long enough for a wrongly raised req to reach the model
        repeat (4) @(posedge clk);
        #1;
        check("hit no rd", rd_before, ba1_reads);
        read_byte(1'b0, 17'h0010, "snd miss");
        check("miss rd", rd_before + 1, ba1_reads);
        read_gfx(18'h0004, 18'h0008);

        // Download clears every slot
        @(posedge clk);
        #1;
        downloading = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        downloading = 1'b0;
        rd_before = ba1_reads;
        read_byte(1'b0, 17'h0010, "snd after clear");
        check("clear rd", rd_before + 1, ba1_reads);
        rd_before = ba2_reads;
        read_gfx(18'h0004, 18'h0008);
        check("clear gfx rd", rd_before + 2, ba2_reads);

        repeat (4) @(posedge clk);
        #1;
        if (dut_i.props_i.prop_fail) begin
            $display("A bound SDRAM assertion failed");
            $display("Verification failed");
            $fatal(1, "Assertion failure");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

//--- build.f
design/sdram_pkg.sv
design/rom_slot.sv
design/bank_arbiter.sv
design/prog_remap.sv
design/sdram_mux_top.sv
sim/sdram_mux_properties.sv
sim/tb_top.sv

//--- Bender.yml
package:
  name: sdram_mux

sources:
  - files:
      - design/sdram_pkg.sv
      - design/rom_slot.sv
      - design/bank_arbiter.sv
      - design/prog_remap.sv
      - design/sdram_mux_top.sv
  - target: simulation
    files:
      - sim/sdram_mux_properties.sv
      - sim/tb_top.sv
